/* common/spiChanIf.sv */
/* Control and status of one SPI channel between the CSR block and a byte engine.
   en is a request held until intr; cs bypasses the engine. */
`timescale 1ns/1ps

interface spiChanIf;

	// Control, driven by the CSR block
	logic            en;	// Start request
	spiPkg::divT     div;	// SCLK half-period minus one
	spiPkg::byteT    wd;	// Byte to send
	logic            cs;	// Chip select, software controlled

	// Status, driven by the engine
	spiPkg::byteT    rd;	// Last received byte
	logic            intr;	// One-cycle done pulse

	modport csr
	(
		output en, div, wd, cs,
		input  rd, intr
	);

	modport engine
	(
		input  en, div, wd,
		output rd, intr
	);

endinterface

/* common/spiPkg.sv */
/* Widths, the CSR address map and shared types of the two-channel SPI master.
   Offsets are byte addresses inside the block; only the low 8 bits reach the read mux. */

package spiPkg;

	// --------------------------------------------------
	// Bus and address map
	// --------------------------------------------------
	localparam int pBusWidth       = 32;
	localparam int pBlockAdrsWidth = 8;		// Block select field
	localparam int pCsrAdrsWidth   = 16;	// Offset field compared on writes
	localparam int pCsrActiveWidth = 8;		// Offset bits seen by read mux
	localparam int pWriteBit       = 30;	// Address bit marking a write
	localparam int pDivWidth       = 16;

	localparam logic [pBlockAdrsWidth-1:0] pAdrsMap = 8'h03;	// Sits in address bits 23:16

	typedef logic [pBusWidth-1:0]     busWordT;
	typedef logic [pDivWidth-1:0]     divT;
	typedef logic [7:0]               byteT;
	typedef logic [pCsrAdrsWidth-1:0] csrOfsT;

	// --------------------------------------------------
	// Register offsets
	// --------------------------------------------------
	// Main channel control
	localparam csrOfsT pRegMainEn    = 16'h0000;
	localparam csrOfsT pRegMainDiv   = 16'h0004;
	localparam csrOfsT pRegMainWd    = 16'h0008;
	localparam csrOfsT pRegMainCs    = 16'h000c;

	// Flash channel control
	localparam csrOfsT pRegFlashEn   = 16'h0010;
	localparam csrOfsT pRegFlashDiv  = 16'h0014;
	localparam csrOfsT pRegFlashWd   = 16'h0018;
	localparam csrOfsT pRegFlashCs   = 16'h001c;

	// Status
	localparam csrOfsT pRegMainRd    = 16'h0080;
	localparam csrOfsT pRegFlashRd   = 16'h0084;
	localparam csrOfsT pRegFlashIntr = 16'h0088;	// Sticky, write clears

	// Byte engine FSM
	typedef enum logic [1:0]
	{
		stIdle,
		stShift,
		stDone
	} engStateT;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module spiTb \
	--Mdir obj_dir \
	-o spiTbSim \
	-f verilog.f

./obj_dir/spiTbSim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log
then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

/* spi/spiByteEngine.sv */
/* One-byte SPI mode-0 shifter, MSB first. Half-period is div+1 clocks; a new byte
   starts only after en has dropped following the done pulse. */
`timescale 1ns/1ps

module spiByteEngine
(
	input  logic     iSCLK,
	input  logic     iSRST,
	spiChanIf.engine chan,
	output logic     sclk,
	output logic     mosi,
	input  logic     miso
);

	spiPkg::engStateT state;
	spiPkg::divT      divCnt;	// Clocks spent in current half-period
	logic [2:0]       bitCnt;	// Falling edges seen
	spiPkg::byteT     shiftReg;	// Tx out of the top, rx in at the bottom
	logic             misoBit;	// Sampled on rising edge
	logic             halfDone;

	// Compare as >= so a div lowered mid-byte cannot stall the counter
	assign halfDone = (divCnt >= chan.div);
	assign mosi     = shiftReg[7];

	// --------------------------------------------------
	// FSM and shift path
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state     <= spiPkg::stIdle;
			sclk      <= 1'b0;
			divCnt    <= '0;
			bitCnt    <= '0;
			shiftReg  <= '0;
			misoBit   <= 1'b0;
			chan.rd   <= '0;
			chan.intr <= 1'b0;
		end
		else
		begin
			chan.intr <= 1'b0;	// Pulse only
			case (state)
				spiPkg::stIdle:
				begin
					if (chan.en)
					begin
						shiftReg <= chan.wd;	// MSB on mosi before first rise
						divCnt   <= '0;
						bitCnt   <= '0;
						sclk     <= 1'b0;
						state    <= spiPkg::stShift;
					end
				end

				spiPkg::stShift:
				begin
					if (halfDone)
					begin
						divCnt <= '0;
						sclk   <= ~sclk;
						if (!sclk)
						begin
							misoBit <= miso;	// Rising edge
						end
						else
						begin
							// Falling edge, next bit out
							shiftReg <= {shiftReg[6:0], misoBit};
							bitCnt   <= bitCnt + 3'd1;
							if (bitCnt == 3'd7)
							begin
								chan.rd   <= {shiftReg[6:0], misoBit};
								chan.intr <= 1'b1;
								state     <= spiPkg::stDone;
							end
						end
					end
					else
					begin
						divCnt <= divCnt + spiPkg::divT'(1);
					end
				end

				spiPkg::stDone:
				begin
					// Hold until the CSR block drops the request
					if (!chan.en)
						state <= spiPkg::stIdle;
				end

				default:
				begin
					state <= spiPkg::stIdle;
				end
			endcase
		end
	end

endmodule

/* spi/spiCsr.sv */
/* CSRs for the main and flash SPI channels. Writes need address bit 30 and a block match;
   read data is registered and shows one cycle after the address, unmapped offsets read 0. */
`timescale 1ns/1ps

module spiCsr
(
	input  logic            iSCLK,
	input  logic            iSRST,
	input  spiPkg::busWordT usiAdrs,
	input  spiPkg::busWordT usiWd,
	output spiPkg::busWordT usiRd,
	spiChanIf.csr           mainChan,
	spiChanIf.csr           flashChan
);

	// --------------------------------------------------
	// Write decode
	// --------------------------------------------------
	logic           blockHit;
	spiPkg::csrOfsT wrOfs;
	spiPkg::csrOfsT rdOfs;

	logic weMainEn;
	logic weMainDiv;
	logic weMainWd;
	logic weMainCs;
	logic weFlashEn;
	logic weFlashDiv;
	logic weFlashWd;
	logic weFlashCs;
	logic weFlashIntr;

	always_comb
	begin
		blockHit = usiAdrs[spiPkg::pWriteBit]
			&& (usiAdrs[spiPkg::pBlockAdrsWidth+spiPkg::pCsrAdrsWidth-1:spiPkg::pCsrAdrsWidth]
				== spiPkg::pAdrsMap);
		wrOfs = usiAdrs[spiPkg::pCsrAdrsWidth-1:0];
		rdOfs = spiPkg::csrOfsT'(usiAdrs[spiPkg::pCsrActiveWidth-1:0]);	// Read ignores block

		weMainEn    = blockHit && (wrOfs == spiPkg::pRegMainEn);
		weMainDiv   = blockHit && (wrOfs == spiPkg::pRegMainDiv);
		weMainWd    = blockHit && (wrOfs == spiPkg::pRegMainWd);
		weMainCs    = blockHit && (wrOfs == spiPkg::pRegMainCs);
		weFlashEn   = blockHit && (wrOfs == spiPkg::pRegFlashEn);
		weFlashDiv  = blockHit && (wrOfs == spiPkg::pRegFlashDiv);
		weFlashWd   = blockHit && (wrOfs == spiPkg::pRegFlashWd);
		weFlashCs   = blockHit && (wrOfs == spiPkg::pRegFlashCs);
		weFlashIntr = blockHit && (wrOfs == spiPkg::pRegFlashIntr);
	end

	// --------------------------------------------------
	// Channel registers and status capture
	// --------------------------------------------------
	logic         mainEn;
	spiPkg::divT  mainDiv;
	spiPkg::byteT mainWd;
	logic         mainCs;
	logic         flashEn;
	spiPkg::divT  flashDiv;
	spiPkg::byteT flashWd;
	logic         flashCs;
	spiPkg::byteT mainRd;
	spiPkg::byteT flashRd;
	logic         flashIntrFlag;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			mainEn        <= 1'b0;
			mainDiv       <= '1;	// Slowest SCLK
			mainWd        <= '0;
			mainCs        <= 1'b1;	// Deselected
			flashEn       <= 1'b0;
			flashDiv      <= '1;
			flashWd       <= '0;
			flashCs       <= 1'b1;
			mainRd        <= '0;
			flashRd       <= '0;
			flashIntrFlag <= 1'b0;
		end
		else
		begin
			// Done pulse drops the request, even against a write
			if (mainChan.intr)
				mainEn <= 1'b0;
			else if (weMainEn)
				mainEn <= usiWd[0];

			if (flashChan.intr)
				flashEn <= 1'b0;
			else if (weFlashEn)
				flashEn <= usiWd[0];

			if (weMainDiv)  mainDiv  <= usiWd[spiPkg::pDivWidth-1:0];
			if (weMainWd)   mainWd   <= usiWd[7:0];
			if (weMainCs)   mainCs   <= usiWd[0];
			if (weFlashDiv) flashDiv <= usiWd[spiPkg::pDivWidth-1:0];
			if (weFlashWd)  flashWd  <= usiWd[7:0];
			if (weFlashCs)  flashCs  <= usiWd[0];

			mainRd <= mainChan.rd;	// Engine holds rd between bytes

			if (flashChan.intr)
				flashRd <= flashChan.rd;

			// Set beats clear
			if (flashChan.intr)
				flashIntrFlag <= 1'b1;
			else if (weFlashIntr)
				flashIntrFlag <= 1'b0;
		end
	end

	assign mainChan.en   = mainEn;
	assign mainChan.div  = mainDiv;
	assign mainChan.wd   = mainWd;
	assign mainChan.cs   = mainCs;
	assign flashChan.en  = flashEn;
	assign flashChan.div = flashDiv;
	assign flashChan.wd  = flashWd;
	assign flashChan.cs  = flashCs;

	// --------------------------------------------------
	// Read mux
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		case (rdOfs)
			spiPkg::pRegMainEn:    usiRd <= spiPkg::busWordT'(mainEn);
			spiPkg::pRegMainDiv:   usiRd <= spiPkg::busWordT'(mainDiv);
			spiPkg::pRegMainWd:    usiRd <= spiPkg::busWordT'(mainWd);
			spiPkg::pRegMainCs:    usiRd <= spiPkg::busWordT'(mainCs);
			spiPkg::pRegFlashEn:   usiRd <= spiPkg::busWordT'(flashEn);
			spiPkg::pRegFlashDiv:  usiRd <= spiPkg::busWordT'(flashDiv);
			spiPkg::pRegFlashWd:   usiRd <= spiPkg::busWordT'(flashWd);
			spiPkg::pRegFlashCs:   usiRd <= spiPkg::busWordT'(flashCs);
			spiPkg::pRegMainRd:    usiRd <= spiPkg::busWordT'(mainRd);
			spiPkg::pRegFlashRd:   usiRd <= spiPkg::busWordT'(flashRd);
			spiPkg::pRegFlashIntr: usiRd <= spiPkg::busWordT'(flashIntrFlag);
			default:               usiRd <= '0;	// Unmapped
		endcase
	end

endmodule

/* testbench/spiSlaveModel.sv */
/* Behavioral SPI mode-0 slave, MSB first. presetByte must stay stable while cs is low;
   recvByte holds the last eight MOSI bits sampled on rising SCLK. */
`timescale 1ns/1ps

module spiSlaveModel
(
	input  logic       sclk,
	input  logic       mosi,
	input  logic       cs,
	output logic       miso,
	input  logic [7:0] presetByte,
	output logic [7:0] recvByte
);

	logic [2:0] txIdx    = 3'd7;	// Bit of presetByte on miso
	logic       sclkPrev = 1'b0;
	logic       started  = 1'b0;	// Rising edge seen since select
	logic [7:0] rxReg    = 8'h00;

	assign miso     = presetByte[txIdx];
	assign recvByte = rxReg;

	always @(posedge sclk or negedge sclk or posedge cs or negedge cs)
	begin
		if (cs)
		begin
			// Deselected, bit count back to the MSB
			txIdx   = 3'd7;
			started = 1'b0;
		end
		else if (sclk && !sclkPrev)
		begin
			rxReg   = {rxReg[6:0], mosi};	// Sample on rise
			started = 1'b1;
		end
		else if (!sclk && sclkPrev && started)
		begin
			txIdx = txIdx - 3'd1;	// Next bit out on fall
		end
		sclkPrev = sclk;
	end

endmodule

/* testbench/spiTb.sv */
/* Testbench for the two-channel SPI master with one behavioral slave per channel.
   Reads present the address on one falling edge and sample usiRd on the next. */
`timescale 1ns/1ps

module spiTb;

	logic            iSCLK;
	logic            iSRST;
	spiPkg::busWordT usiAdrs;
	spiPkg::busWordT usiWd;
	spiPkg::busWordT usiRd;
	logic            mainSclk;
	logic            mainMosi;
	logic            mainCs;
	logic            mainMiso;
	logic            flashSclk;
	logic            flashMosi;
	logic            flashCs;
	logic            flashMiso;
	spiPkg::byteT    mainPreset;
	spiPkg::byteT    flashPreset;
	spiPkg::byteT    mainRecv;
	spiPkg::byteT    flashRecv;

	// Register model
	spiPkg::busWordT ctrlMdl [8];	// Offsets 0x00 to 0x1c as written
	spiPkg::byteT    mainRdMdl;
	spiPkg::byteT    flashRdMdl;
	logic            flashIntrMdl;

	logic [7:0] mappedOfs [11] = '{8'h00, 8'h04, 8'h08, 8'h0c, 8'h10, 8'h14,
		8'h18, 8'h1c, 8'h80, 8'h84, 8'h88};
	logic [7:0] unmappedOfs [5] = '{8'h20, 8'h40, 8'h7c, 8'h8c, 8'hfc};
	logic [7:0] rwOfs [6] = '{8'h04, 8'h08, 8'h0c, 8'h14, 8'h18, 8'h1c};

	int errCnt  = 0;
	int testErr = 0;
	int testNum = 0;
	int passCnt = 0;
	int failCnt = 0;

	// SCLK period monitor
	logic sclkWatch = 1'b0;
	logic sclkPrev  = 1'b0;
	int   cyc       = 0;
	int   lastRise  = 0;
	int   riseCnt   = 0;
	int   periods [$];

	spiTop dut_i
	(
		.iSCLK (iSCLK), .iSRST (iSRST),
		.usiAdrs (usiAdrs), .usiWd (usiWd), .usiRd (usiRd),
		.mainSclk (mainSclk), .mainMosi (mainMosi), .mainCs (mainCs), .mainMiso (mainMiso),
		.flashSclk (flashSclk), .flashMosi (flashMosi), .flashCs (flashCs),
		.flashMiso (flashMiso)
	);

	spiSlaveModel mainSlave_i (.sclk (mainSclk), .mosi (mainMosi), .cs (mainCs),
		.miso (mainMiso), .presetByte (mainPreset), .recvByte (mainRecv));
	spiSlaveModel flashSlave_i (.sclk (flashSclk), .mosi (flashMosi), .cs (flashCs),
		.miso (flashMiso), .presetByte (flashPreset), .recvByte (flashRecv));

	always #10 iSCLK = ~iSCLK;

	always @(negedge iSCLK)
	begin
		cyc = cyc + 1;
		if (!sclkWatch)
		begin
			riseCnt = 0;
			periods.delete();
		end
		else if (mainSclk && !sclkPrev)
		begin
			if (riseCnt > 0)
				periods.push_back(cyc - lastRise);
			lastRise = cyc;
			riseCnt  = riseCnt + 1;
		end
		sclkPrev = mainSclk;
	end

	// --------------------------------------------------
	// Reference model and compare
	// --------------------------------------------------
	function automatic spiPkg::busWordT expectRead(input logic [7:0] ofs);
		spiPkg::busWordT v;
		v = '0;
		case (ofs)
			8'h00, 8'h0c, 8'h10, 8'h1c: v = {31'b0, ctrlMdl[ofs[4:2]][0]};
			8'h04, 8'h14:               v = {16'b0, ctrlMdl[ofs[4:2]][15:0]};
			8'h08, 8'h18:               v = {24'b0, ctrlMdl[ofs[4:2]][7:0]};
			8'h80:                      v = {24'b0, mainRdMdl};
			8'h84:                      v = {24'b0, flashRdMdl};
			8'h88:                      v = {31'b0, flashIntrMdl};
			default:                    v = '0;	// Unmapped
		endcase
		return v;
	endfunction

	task automatic compareValue(input string name, input spiPkg::busWordT exp,
		input spiPkg::busWordT act);
		assert (act === exp)
		else
		begin
			$display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			errCnt++;
		end
	endtask

	// --------------------------------------------------
	// Bus access
	// --------------------------------------------------
	task automatic busWriteAdrs(input spiPkg::busWordT adrs, input spiPkg::busWordT data);
		@(negedge iSCLK);
		usiAdrs = adrs;
		usiWd   = data;
		@(negedge iSCLK);
		usiAdrs = '0;
		usiWd   = '0;
	endtask

	task automatic busWrite(input logic [7:0] ofs, input spiPkg::busWordT data);
		busWriteAdrs({2'b01, 6'b0, spiPkg::pAdrsMap, 8'h00, ofs}, data);
		if (ofs < 8'h20)
			ctrlMdl[ofs[4:2]] = data;
		if (ofs == 8'h88)
			flashIntrMdl = 1'b0;
	endtask

	task automatic busRead(input logic [7:0] ofs, output spiPkg::busWordT data);
		@(negedge iSCLK);
		usiAdrs = {2'b00, 6'b0, spiPkg::pAdrsMap, 8'h00, ofs};
		@(negedge iSCLK);
		data = usiRd;
	endtask

	task automatic checkReg(input logic [7:0] ofs);
		spiPkg::busWordT act;
		busRead(ofs, act);
		compareValue($sformatf("usiRd[%02h]", ofs), expectRead(ofs), act);
	endtask

	task automatic checkAllRegs();
		foreach (mappedOfs[i])
			checkReg(mappedOfs[i]);
	endtask

	task automatic waitEnClear(input logic [7:0] ofs, input int limit);
		spiPkg::busWordT val;
		int polls;
		val   = 32'h1;
		polls = 0;
		while (val[0] && polls < limit)
		begin
			busRead(ofs, val);
			polls++;
		end
		if (val[0])
		begin
			$display("Timeout: enable at offset %02h still set after %0d reads", ofs, limit);
			errCnt++;
		end
	endtask

	// --------------------------------------------------
	// Transfers
	// --------------------------------------------------
	task automatic startTransfer(input logic flash, input spiPkg::byteT wd,
		input spiPkg::divT div, input spiPkg::byteT slv);
		logic [7:0] base;
		base = flash ? 8'h10 : 8'h00;
		if (flash)
			flashPreset = slv;
		else
			mainPreset = slv;
		busWrite(base + 8'h04, spiPkg::busWordT'(div));
		busWrite(base + 8'h08, spiPkg::busWordT'(wd));
		busWrite(base + 8'h0c, 32'h0);	// Select the slave
		busWrite(base, 32'h1);
	endtask

	task automatic finishTransfer(input logic flash, input spiPkg::byteT wd,
		input spiPkg::byteT slv);
		logic [7:0] base;
		base = flash ? 8'h10 : 8'h00;
		waitEnClear(base, 500);
		ctrlMdl[base[4:2]] = '0;	// en drops on done
		if (flash)
		begin
			flashRdMdl   = slv;
			flashIntrMdl = 1'b1;
			compareValue("flashSlave recvByte", spiPkg::busWordT'(wd),
				spiPkg::busWordT'(flashRecv));
		end
		else
		begin
			mainRdMdl = slv;
			compareValue("mainSlave recvByte", spiPkg::busWordT'(wd),
				spiPkg::busWordT'(mainRecv));
		end
		busWrite(base + 8'h0c, 32'h1);
	endtask

	task automatic endTest(input string name);
		testNum++;
		if (errCnt == testErr)
		begin
			passCnt++;
			$display("test %0d %s: ok", testNum, name);
		end
		else
		begin
			failCnt++;
			$display("test %0d %s: %0d errors", testNum, name, errCnt - testErr);
		end
		testErr = errCnt;
	endtask

	// Global limit on the run
	initial
	begin
		repeat (200000) @(posedge iSCLK);
		$display("Watchdog: run did not finish within 200000 cycles");
		$display("sim failed");
		$finish;
	end

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	initial
	begin
		spiPkg::byteT wd;
		spiPkg::byteT slv;
		spiPkg::divT  div;
		int unsigned  pick;

		void'($urandom(32'h3d07));
		iSCLK       = 1'b0;
		iSRST       = 1'b1;
		usiAdrs     = '0;
		usiWd       = '0;
		mainPreset  = '0;
		flashPreset = '0;
		for (int i = 0; i < 8; i++)
			ctrlMdl[i] = (i % 4 == 1) ? 32'hffff : ((i % 4 == 3) ? 32'h1 : 32'h0);
		mainRdMdl    = '0;
		flashRdMdl   = '0;
		flashIntrMdl = 1'b0;
		repeat (4) @(posedge iSCLK);
		@(negedge iSCLK);
		iSRST = 1'b0;

		checkAllRegs();
		foreach (unmappedOfs[i])
			checkReg(unmappedOfs[i]);
		endTest("reset values");

		for (int i = 0; i < 24; i++)
		begin
			pick = $urandom % 6;
			busWrite(rwOfs[pick], $urandom);
			checkReg(rwOfs[pick]);
		end
		busWriteAdrs({2'b00, 6'b0, spiPkg::pAdrsMap, 16'h0004}, $urandom);	// No write bit
		busWriteAdrs({2'b01, 6'b0, 8'h04, 16'h0018}, $urandom);	// Other block
		checkAllRegs();
		endTest("register read back");

		wd  = spiPkg::byteT'($urandom);
		slv = spiPkg::byteT'($urandom);
		div = spiPkg::divT'($urandom % 4);
		startTransfer(1'b0, wd, div, slv);
		compareValue("mainCs", 32'h0, spiPkg::busWordT'(mainCs));
		finishTransfer(1'b0, wd, slv);
		compareValue("mainCs", 32'h1, spiPkg::busWordT'(mainCs));
		checkAllRegs();
		endTest("main transfer");

		wd  = spiPkg::byteT'($urandom);
		slv = spiPkg::byteT'($urandom);
		div = spiPkg::divT'($urandom % 4);
		startTransfer(1'b1, wd, div, slv);
		compareValue("flashCs", 32'h0, spiPkg::busWordT'(flashCs));
		finishTransfer(1'b1, wd, slv);
		compareValue("flashCs", 32'h1, spiPkg::busWordT'(flashCs));
		checkReg(8'h88);
		busWrite(8'h88, 32'h0);
		checkAllRegs();
		endTest("flash transfer");

		wd  = spiPkg::byteT'($urandom);
		slv = spiPkg::byteT'($urandom);
		div = spiPkg::divT'(1 + $urandom % 3);
		sclkWatch = 1'b1;
		startTransfer(1'b0, wd, div, slv);
		finishTransfer(1'b0, wd, slv);
		compareValue("mainSclk rising edges", 32'd8, spiPkg::busWordT'(riseCnt));
		foreach (periods[i])
			compareValue($sformatf("mainSclk period %0d", i),
				spiPkg::busWordT'(2 * (div + 1)), spiPkg::busWordT'(periods[i]));
		sclkWatch = 1'b0;
		endTest("sclk timing");

		for (int i = 0; i < 2; i++)
		begin
			wd     = spiPkg::byteT'($urandom);
			slv    = spiPkg::byteT'($urandom);
			div    = spiPkg::divT'($urandom % 4);
			startTransfer(1'b1, wd, div, slv);
			checkReg(8'h84);	// Still the previous byte mid-transfer
			finishTransfer(1'b1, wd, slv);
			checkReg(8'h84);
		end
		checkAllRegs();
		endTest("back-to-back flash");

		$display("tests ok %0d, tests failing %0d, errors %0d", passCnt, failCnt, errCnt);
		if (errCnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* verilog.f */
common/spiPkg.sv
common/spiChanIf.sv
spi/spiCsr.sv
spi/spiByteEngine.sv
verilog/spiTop.sv
testbench/spiSlaveModel.sv
testbench/spiTb.sv

/* verilog/spiTop.sv */
/* Two-channel SPI master on the simple CSR bus. Chip selects come straight from the
   CS registers; the engines only drive SCLK and MOSI. */
`timescale 1ns/1ps

module spiTop
(
	input  logic            iSCLK,
	input  logic            iSRST,
	// CSR bus
	input  spiPkg::busWordT usiAdrs,
	input  spiPkg::busWordT usiWd,
	output spiPkg::busWordT usiRd,
	// General SPI devices
	output logic            mainSclk,
	output logic            mainMosi,
	output logic            mainCs,
	input  logic            mainMiso,
	// Serial flash
	output logic            flashSclk,
	output logic            flashMosi,
	output logic            flashCs,
	input  logic            flashMiso
);

	spiChanIf mainChan ();
	spiChanIf flashChan ();

	// --------------------------------------------------
	// CSR block
	// --------------------------------------------------
	spiCsr csr_i
	(
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.usiAdrs   (usiAdrs),
		.usiWd     (usiWd),
		.usiRd     (usiRd),
		.mainChan  (mainChan.csr),
		.flashChan (flashChan.csr)
	);

	// --------------------------------------------------
	// Byte engines
	// --------------------------------------------------
	spiByteEngine mainEng_i
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.chan  (mainChan.engine),
		.sclk  (mainSclk),
		.mosi  (mainMosi),
		.miso  (mainMiso)
	);

	spiByteEngine flashEng_i
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST),
		.chan  (flashChan.engine),
		.sclk  (flashSclk),
		.mosi  (flashMosi),
		.miso  (flashMiso)
	);

	assign mainCs  = mainChan.cs;	// Software chip select
	assign flashCs = flashChan.cs;

endmodule
